// File: sim/qsound_stimulus.txt
# op addr data expect, all hex; rom: data is rom_data, expect is rom_addr
# aud: addr is the left word, data the right word, output computed by the testbench
rom 1234 a5 01234
zwr d003 82 0
rom 9234 3c 11234
zwr c010 11 0
zrd c010 0 11
zwr f123 22 0
zrd f123 0 22
zrd e000 0 ff
mwr c020 5a 0
zrd c020 0 5a
zwr d000 12 0
zwr d001 34 0
zwr d002 56 0
irq 0 0 1
zrd d007 0 72
cmd 0 0 561234
pbw 0 0 0056
pid 0 0 0
pid 0 0 0
irq 0 0 0
pbw 0 0 1234
zrd d007 0 f2
aud 4000 2000 0
aud 8000 7ffe 0
aud 1234 f000 0
wat 4000 0 1
int 0 0 0
pod 8025 4321 254321

// File: project.f
+incdir+logic
logic/z80_bus_pkg.sv
logic/dsp_link_pkg.sv
logic/sound_bus_map.sv
logic/main_bus_arbiter.sv
logic/z80_cycle_ctrl.sv
logic/qsound_mailbox.sv
logic/qsound_audio.sv
logic/qsound_sound.sv
sim/qsound_sound_props.sv
sim/qsound_sound_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= qsound_sound_tb
FILELIST  ?= project.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/qsound_sound_tb.sv
// stimulus comes from sim/qsound_stimulus.txt relative to the run directory; cen8 is every 6th clk48
`timescale 1ns/10ps
`include "qsnd_macros.svh"

module qsound_sound_tb;
    import z80_bus_pkg::*;
    import dsp_link_pkg::*;

    logic        clk48;
    logic        rst;
    logic        cen8;
    z80_bus_t    cpu;
    logic        busak_n;
    logic        busrq_n;
    logic        int_n;
    logic        cpu_cen;
    logic [7:0]  cpu_din;
    logic [16:1] main_addr;
    logic [7:0]  main_dout;
    logic        main_ldswn;
    logic        main_buse_n;
    logic [7:0]  main_din;
    logic        main_busakn;
    logic        z80_buswn;
    logic [7:0]  rom_data;
    logic        rom_ok;
    logic [18:0] rom_addr;
    logic [3:0]  bank;
    dsp_port_t   dsp;
    logic        dsp_rst;
    logic        dsp_irq;
    qsnd_cmd_t   cmd;
    logic [15:0] pbus_in;
    logic [22:0] qsnd_addr;
    stereo_t     out;
    logic        sample;

    // stimulus columns, one entry per file line
    logic [31:0] ops[$];
    logic [31:0] addrs[$];
    logic [31:0] datas[$];
    logic [31:0] exps[$];
    int          n_ops = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cen_cnt = 0;
    int          cen_ticks = 0;   // cen8 edges seen since reset

    // reference model of the averaging filter
    logic signed [15:0] cap_l = 16'sd0;
    logic signed [15:0] cap_r = 16'sd0;
    logic signed [15:0] mdl_l = 16'sd0;
    logic signed [15:0] mdl_r = 16'sd0;

    qsound_sound u_qsound_sound (.*);

    initial begin
        clk48 = 1'b0;
        forever #50 clk48 = ~clk48;
    end

    initial begin
        cen8 = 1'b0;
        forever begin
            @(posedge clk48);
            if (!rst && cen8)
                cen_ticks++;   // same edges the interrupt timer counts
            #10;
            cen_cnt = (cen_cnt == 5) ? 0 : cen_cnt + 1;
            cen8    = cen_cnt == 5;
        end
    end

    task automatic next_cycle;
        @(posedge clk48);
        #10;
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_addr(input string name, input logic [22:0] exp, input logic [22:0] got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_cmd(input qsnd_cmd_t exp, input qsnd_cmd_t got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t ns: cmd expected %h got %h", $time, exp, got);
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_stereo(input stereo_t exp, input stereo_t got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t ns: out expected %h got %h", $time, exp, got);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t ns: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic z80_write(input logic [15:0] addr, input logic [7:0] data);
        cpu.addr   = addr;
        cpu.dout   = data;
        cpu.mreq_n = 1'b0;
        cpu.wr_n   = 1'b0;
        next_cycle();
        next_cycle();
        cpu.mreq_n = 1'b1;
        cpu.wr_n   = 1'b1;   // dout stays, the write may repeat once
        next_cycle();
        next_cycle();
    endtask

    task automatic z80_read(input logic [15:0] addr, output logic [7:0] data,
                            output logic [18:0] raddr, output logic [7:0] mdata);
        cpu.addr   = addr;
        cpu.mreq_n = 1'b0;
        cpu.rd_n   = 1'b0;
        next_cycle();
        next_cycle();
        data       = cpu_din;
        raddr      = rom_addr;
        cpu.mreq_n = 1'b1;
        cpu.rd_n   = 1'b1;
        next_cycle();
        mdata = main_din;   // 68000 copy, one cycle behind cpu_din
    endtask

    // 68000 takes the bus, writes one byte and hands the bus back
    task automatic main_write(input logic [15:0] addr, input logic [7:0] data);
        int k;
        int t0;
        k           = 0;
        main_addr   = addr;
        main_dout   = data;
        main_ldswn  = 1'b1;
        main_buse_n = 1'b0;
        next_cycle();
        check_level("busrq_n", 1'b0, busrq_n);
        busak_n = 1'b0;   // Z80 acknowledges
        t0      = cen_ticks;
        while (main_busakn && k < 40) begin
            next_cycle();
            k++;
        end
        if (main_busakn) begin
            n_errors++;
            $display("the main CPU was never granted the bus");
        end else begin
            check_byte("cen8 ticks to grant", 8'd2, 8'(cen_ticks - t0));
        end
        main_ldswn = 1'b0;
        next_cycle();
        check_level("z80_buswn", 1'b0, z80_buswn);
        next_cycle();
        main_ldswn = 1'b1;
        next_cycle();
        main_buse_n = 1'b1;
        next_cycle();
        busak_n = 1'b1;
        check_level("main_busakn", 1'b1, main_busakn);
        check_level("z80_buswn", 1'b1, z80_buswn);
        next_cycle();
    endtask

    task automatic pids_pulse;
        dsp.pids_n = 1'b0;
        next_cycle();
        dsp.pids_n = 1'b1;
        next_cycle();
        next_cycle();
    endtask

    // left word, psel rise that starts a sample, then right word
    task automatic audio_pair(input logic [15:0] lw, input logic [15:0] rw);
        int k;
        k           = 0;
        dsp.psel    = 1'b0;
        dsp.ser_out = lw;
        dsp.sadd    = 1'b1;
        next_cycle();
        dsp.sadd = 1'b0;
        next_cycle();
        cap_l    = lw;
        dsp.psel = 1'b1;
        mdl_l    = (mdl_l >>> 1) + (cap_l >>> 1);
        mdl_r    = (mdl_r >>> 1) + (cap_r >>> 1);
        next_cycle();
        while (!sample && k < 8) begin
            next_cycle();
            k++;
        end
        if (!sample) begin
            n_errors++;
            $display("no sample pulse came after the psel rise");
        end else begin
            check_stereo({mdl_l, mdl_r}, out);
        end
        dsp.ser_out = rw;
        dsp.sadd    = 1'b1;
        next_cycle();
        dsp.sadd = 1'b0;
        next_cycle();
        cap_r = rw;
    endtask

    task automatic opcode_wait(input logic [15:0] addr, input logic [7:0] exp_lost);
        int ticks;
        int kept;
        ticks      = 0;
        kept       = 0;
        cpu.addr   = addr;
        cpu.m1_n   = 1'b0;
        cpu.mreq_n = 1'b0;
        cpu.rd_n   = 1'b0;
        repeat (48) begin
            @(negedge clk48);
            if (cen8)
                ticks++;
            if (cpu_cen)
                kept++;
        end
        next_cycle();
        cpu.m1_n   = 1'b1;
        cpu.mreq_n = 1'b1;
        cpu.rd_n   = 1'b1;
        next_cycle();
        check_byte("cpu_cen ticks lost", exp_lost, 8'(ticks - kept));
    endtask

    // int_n must hold until the last tick of the first period, then fall
    task automatic interrupt_ack;
        int k;
        k        = 0;
        cpu.addr = 16'h0000;
        while (cen_ticks < `QSND_INT_PERIOD - 1 && k < `QSND_INT_PERIOD * 6 + 60) begin
            next_cycle();
            k++;
        end
        check_level("int_n before the period", 1'b1, int_n);
        while (cen_ticks < `QSND_INT_PERIOD && k < `QSND_INT_PERIOD * 6 + 60) begin
            next_cycle();
            k++;
        end
        check_level("int_n", 1'b0, int_n);
        cpu.m1_n   = 1'b0;
        cpu.iorq_n = 1'b0;
        k          = 0;
        while (!int_n && k < 20) begin
            next_cycle();
            k++;
        end
        check_level("int_n after acknowledge", 1'b1, int_n);
        cpu.m1_n   = 1'b1;
        cpu.iorq_n = 1'b1;
        next_cycle();
    endtask

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          code;
        string       line;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        ok = 1'b0;
        fd = $fopen("sim/qsound_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != 8'h23) begin
                    if ($sscanf(line, "%s %h %h %h", op, a, d, e) == 4) begin
                        ops.push_back(op);
                        addrs.push_back(a);
                        datas.push_back(d);
                        exps.push_back(e);
                    end
                end
            end
            $fclose(fd);
            ok = ops.size() > 0;
        end
    endtask

    initial begin
        bit          loaded;
        int          errs_before;
        logic [7:0]  got;
        logic [7:0]  md;
        logic [18:0] ra;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        rst         = 1'b1;
        cpu.addr    = 16'h0000;
        cpu.dout    = 8'h00;
        cpu.mreq_n  = 1'b1;
        cpu.rd_n    = 1'b1;
        cpu.wr_n    = 1'b1;
        cpu.m1_n    = 1'b1;
        cpu.iorq_n  = 1'b1;
        busak_n     = 1'b1;
        main_addr   = 16'h0000;
        main_dout   = 8'h00;
        main_ldswn  = 1'b1;
        main_buse_n = 1'b1;
        rom_data    = 8'h00;
        rom_ok      = 1'b1;
        dsp         = '0;
        dsp.pids_n  = 1'b1;
        dsp.pods_n  = 1'b1;
        load_stimulus(loaded);
        if (!loaded) begin
            $display("the stimulus file could not be read");
            $display("sim failed");
            $finish;
        end else begin
            n_ops = ops.size();
            repeat (2) @(posedge clk48);
            #10;
            rst = 1'b0;
            next_cycle();
            check_level("dsp_rst", 1'b1, dsp_rst);   // DSP held in reset until bank bit 7
            check_byte("bank", 8'h00, {4'd0, bank});
            for (int i = 0; i < n_ops; i++) begin
                errs_before = n_errors;
                a = addrs[i];
                d = datas[i];
                e = exps[i];
                case (ops[i])
                    "rom": begin
                        rom_data = d[7:0];
                        z80_read(a[15:0], got, ra, md);
                        check_addr("rom_addr", e[22:0], {4'd0, ra});
                        check_byte("cpu_din", d[7:0], got);
                        check_byte("main_din", d[7:0], md);
                    end
                    "zwr": begin
                        z80_write(a[15:0], d[7:0]);
                        if (a[15:12] == 4'hd && a[2:0] == `QSND_REG_BANK) begin
                            check_byte("bank", {4'd0, d[3:0]}, {4'd0, bank});
                            check_level("dsp_rst", ~d[7], dsp_rst);
                        end
                    end
                    "zrd": begin
                        z80_read(a[15:0], got, ra, md);
                        check_byte("cpu_din", e[7:0], got);
                    end
                    "mwr": main_write(a[15:0], d[7:0]);
                    "irq": check_level("dsp_irq", e[0], dsp_irq);
                    "cmd": check_cmd(qsnd_cmd_t'(e[23:0]), cmd);
                    "pbw": check_word("pbus_in", e[15:0], pbus_in);
                    "pid": pids_pulse();
                    "aud": audio_pair(a[15:0], d[15:0]);
                    "wat": opcode_wait(a[15:0], e[7:0]);
                    "int": interrupt_ack();
                    "pod": begin
                        dsp.ab       = a[15:0];
                        dsp.pbus_out = d[15:0];
                        dsp.pods_n   = 1'b0;
                        next_cycle();
                        dsp.pods_n = 1'b1;
                        next_cycle();
                        check_addr("qsnd_addr", e[22:0], qsnd_addr);
                    end
                    default: begin
                        n_errors++;
                        $display("stimulus line %0d has an unknown operation", i + 1);
                    end
                endcase
                $display("test %0d: %s", i + 1, n_errors == errs_before ? "ok" : "mismatch");
            end
            $display("%0d checks, %0d errors", n_checks, n_errors);
            if (n_errors == 0)
                $display("sim passed");
            else
                $display("sim failed");
            $finish;
        end
    end

    // limit from the file length plus two interrupt periods
    initial begin
        wait (n_ops > 0);
        repeat (n_ops * 40 + 2 * `QSND_INT_PERIOD * 6) @(posedge clk48);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

// File: sim/qsound_sound_props.sv
// bound into the top level; all checks sampled on clk48 and ignored during reset
`timescale 1ns/10ps

module qsound_sound_props (
    input logic clk48,
    input logic rst,
    input logic sample,
    input logic dsp_irq,
    input logic mbox_wr,
    input logic main_busn,
    input logic main_buse_n,
    input logic int_n
);

    assert property (@(posedge clk48) disable iff (rst) sample |=> !sample)
        else $error("sample held high for more than one cycle");

    // irq only comes from a mailbox write
    assert property (@(posedge clk48) disable iff (rst) $rose(dsp_irq) |-> $past(mbox_wr))
        else $error("dsp_irq rose without a mailbox write");

    assert property (@(posedge clk48) disable iff (rst) $fell(main_busn) |-> !main_buse_n)
        else $error("bus granted with no request from the main CPU");

    assert property (@(posedge clk48) rst |-> int_n)
        else $error("int_n low during reset");

endmodule

bind qsound_sound qsound_sound_props u_props (
    .clk48       (clk48),
    .rst         (rst),
    .sample      (sample),
    .dsp_irq     (dsp_irq),
    .mbox_wr     (sel.mbox_wr),
    .main_busn   (main_busn),
    .main_buse_n (main_buse_n),
    .int_n       (int_n)
);

// File: logic/qsound_sound.sv
// Z80 and DSP16 cores sit outside; everything runs on clk48 with cen8 as the Z80 enable
`timescale 1ns/10ps

module qsound_sound (
    input  logic                    clk48,
    input  logic                    rst,
    input  logic                    cen8,
    input  z80_bus_pkg::z80_bus_t   cpu,
    input  logic                    busak_n,
    output logic                    busrq_n,
    output logic                    int_n,
    output logic                    cpu_cen,
    output logic [7:0]              cpu_din,
    input  logic [16:1]             main_addr,
    input  logic [7:0]              main_dout,
    input  logic                    main_ldswn,
    input  logic                    main_buse_n,
    output logic [7:0]              main_din,
    output logic                    main_busakn,
    output logic                    z80_buswn,
    input  logic [7:0]              rom_data,
    input  logic                    rom_ok,
    output logic [18:0]             rom_addr,
    output logic [3:0]              bank,
    input  dsp_link_pkg::dsp_port_t dsp,
    output logic                    dsp_rst,
    output logic                    dsp_irq,
    output dsp_link_pkg::qsnd_cmd_t cmd,
    output logic [15:0]             pbus_in,
    output logic [22:0]             qsnd_addr,
    output dsp_link_pkg::stereo_t   out,
    output logic                    sample
);
    import z80_bus_pkg::*;

    sound_sel_t sel;
    logic       main_busn;   // grant, low for the 68000
    logic [2:0] reg_num;
    logic [7:0] bus_din;
    logic       dsp_rdy_n;

    main_bus_arbiter u_arbiter (
        .clk48       (clk48),
        .rst         (rst),
        .cen8        (cen8),
        .main_buse_n (main_buse_n),
        .busak_n     (busak_n),
        .main_ldswn  (main_ldswn),
        .busrq_n     (busrq_n),
        .main_busn   (main_busn),
        .z80_buswn   (z80_buswn)
    );

    sound_bus_map u_bus_map (
        .clk48       (clk48),
        .rst         (rst),
        .cpu         (cpu),
        .main_busn   (main_busn),
        .main_addr   (main_addr),
        .main_ldswn  (main_ldswn),
        .main_dout   (main_dout),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .dsp_rdy_n   (dsp_rdy_n),
        .sel         (sel),
        .reg_num     (reg_num),
        .bus_din     (bus_din),
        .rom_addr    (rom_addr),
        .cpu_din     (cpu_din),
        .main_din    (main_din),
        .main_busakn (main_busakn),
        .bank        (bank),
        .dsp_rst     (dsp_rst)
    );

    z80_cycle_ctrl u_cycle (
        .clk48     (clk48),
        .rst       (rst),
        .cen8      (cen8),
        .m1_n      (cpu.m1_n),
        .iorq_n    (cpu.iorq_n),
        .addr_page (cpu.addr[15:12]),   // Z80 fetch address, not the shared bus
        .int_n     (int_n),
        .cpu_cen   (cpu_cen)
    );

    qsound_mailbox u_mailbox (
        .clk48     (clk48),
        .rst       (rst),
        .mbox_wr   (sel.mbox_wr),
        .reg_num   (reg_num),
        .bus_din   (bus_din),
        .dsp       (dsp),
        .cmd       (cmd),
        .pbus_in   (pbus_in),
        .dsp_irq   (dsp_irq),
        .dsp_rdy_n (dsp_rdy_n),
        .qsnd_addr (qsnd_addr)
    );

    qsound_audio u_audio (
        .clk48  (clk48),
        .rst    (rst),
        .dsp    (dsp),
        .out    (out),
        .sample (sample)
    );

endmodule

// File: logic/qsound_audio.sv
// ser_out is taken as a parallel word; output is a plain two-point average, no stale override
`timescale 1ns/10ps

module qsound_audio (
    input  logic                    clk48,
    input  logic                    rst,
    input  dsp_link_pkg::dsp_port_t dsp,
    output dsp_link_pkg::stereo_t   out,
    output logic                    sample
);
    import dsp_link_pkg::*;

    stereo_t cap;   // last words from the DSP
    logic    last_sadd;
    logic    last_psel;

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            cap       <= '0;
            out       <= '0;
            sample    <= 1'b0;
            last_sadd <= 1'b0;
            last_psel <= 1'b0;
        end else begin
            last_sadd <= dsp.sadd;
            last_psel <= dsp.psel;
            sample    <= 1'b0;
            if (!dsp.sadd && last_sadd) begin
                if (!dsp.psel)
                    cap.left <= dsp.ser_out;
                else
                    cap.right <= dsp.ser_out;
            end
            if (dsp.psel && !last_psel) begin
                sample    <= 1'b1;
                out.left  <= ($signed(out.left) >>> 1) + ($signed(cap.left) >>> 1);
                out.right <= ($signed(out.right) >>> 1) + ($signed(cap.right) >>> 1);
            end
        end
    end

endmodule

// File: logic/qsound_mailbox.sv
// DSP strobes are sampled on clk48, so their edges are seen one cycle late
`timescale 1ns/10ps
`include "qsnd_macros.svh"

module qsound_mailbox (
    input  logic                    clk48,
    input  logic                    rst,
    input  logic                    mbox_wr,
    input  logic [2:0]              reg_num,
    input  logic [7:0]              bus_din,
    input  dsp_link_pkg::dsp_port_t dsp,
    output dsp_link_pkg::qsnd_cmd_t cmd,
    output logic [15:0]             pbus_in,
    output logic                    dsp_irq,
    output logic                    dsp_rdy_n,
    output logic [22:0]             qsnd_addr
);

    logic [1:0] datasel;   // bit 1 selects the address byte
    logic       last_pids_n;
    logic       last_pods_n;
    logic       pids_rise;

    assign pids_rise = dsp.pids_n && !last_pids_n;
    assign dsp_rdy_n = ~(dsp_irq | dsp.iack);
    assign pbus_in   = datasel[1] ? {8'd0, cmd.addr} : cmd.data;

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            cmd         <= '0;
            dsp_irq     <= 1'b0;
            datasel     <= 2'b00;
            last_pids_n <= 1'b1;
        end else begin
            last_pids_n <= dsp.pids_n;
            if (mbox_wr) begin
                case (reg_num)
                    `QSND_REG_DATA_HI: cmd.data[15:8] <= bus_din;
                    `QSND_REG_DATA_LO: cmd.data[7:0]  <= bus_din;
                    `QSND_REG_ADDR:    cmd.addr       <= bus_din;
                    default:           cmd            <= cmd;
                endcase
            end
            if (mbox_wr && reg_num == `QSND_REG_ADDR) begin
                dsp_irq <= 1'b1;
                datasel <= 2'b11;   // address first, then data
            end else if (pids_rise) begin
                dsp_irq <= 1'b0;
                datasel <= datasel >> 1;
            end
        end
    end

    // sample ROM address, low word from pbus, bank bits from ab
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            qsnd_addr   <= 23'd0;
            last_pods_n <= 1'b1;
        end else begin
            last_pods_n <= dsp.pods_n;
            if (dsp.pods_n && !last_pods_n)
                qsnd_addr[15:0] <= dsp.pbus_out;
            if (dsp.ab[15])
                qsnd_addr[22:16] <= dsp.ab[6:0];
        end
    end

endmodule

// File: logic/z80_cycle_ctrl.sv
// only the first opcode fetch at 4000 or above after reset gets the extra wait
`timescale 1ns/10ps
`include "qsnd_macros.svh"

module z80_cycle_ctrl (
    input  logic       clk48,
    input  logic       rst,
    input  logic       cen8,
    input  logic       m1_n,
    input  logic       iorq_n,
    input  logic [3:0] addr_page,
    output logic       int_n,
    output logic       cpu_cen
);

    logic [14:0] cnt;
    logic        cnt_over;
    logic        idle;        // masks one cen8 tick
    logic        wait_used;

    assign cnt_over = cnt == 15'(`QSND_INT_PERIOD - 1);
    assign cpu_cen  = cen8 & ~idle;

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            cnt   <= 15'd0;
            int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= cnt_over ? 15'd0 : cnt + 15'd1;
            if (!m1_n && !iorq_n)
                int_n <= 1'b1;   // acknowledge cycle
            else if (cnt_over)
                int_n <= 1'b0;
        end
    end

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            idle      <= 1'b0;
            wait_used <= 1'b0;
        end else if (cen8) begin
            idle <= 1'b0;
            if (addr_page >= 4'h4 && !m1_n && !wait_used) begin
                idle      <= 1'b1;
                wait_used <= 1'b1;
            end
        end
    end

endmodule

// File: logic/main_bus_arbiter.sv
// grant follows busak_n by two cen8 ticks; release is taken on the next clk48 edge
`timescale 1ns/10ps

module main_bus_arbiter (
    input  logic clk48,
    input  logic rst,
    input  logic cen8,
    input  logic main_buse_n,   // bus request from the 68000
    input  logic busak_n,
    input  logic main_ldswn,
    output logic busrq_n,
    output logic main_busn,
    output logic z80_buswn
);

    logic [1:0] grant_sr;   // low bits mean granted

    assign busrq_n   = main_buse_n;
    assign main_busn = grant_sr[1];
    assign z80_buswn = main_ldswn | main_busn;   // 68000 write seen by the Z80 bus

    always_ff @(posedge clk48, posedge rst) begin
        if (rst)
            grant_sr <= 2'b11;
        else if (main_buse_n)
            grant_sr <= 2'b11;   // drop the grant at once
        else if (cen8)
            grant_sr <= {grant_sr[0], busrq_n | busak_n};
    end

endmodule

// File: logic/sound_bus_map.sv
// selects lag the bus by one clk48 cycle; the 68000 sees the map through A16-A1 only
`timescale 1ns/10ps
`include "qsnd_macros.svh"

module sound_bus_map (
    input  logic                    clk48,
    input  logic                    rst,
    input  z80_bus_pkg::z80_bus_t   cpu,
    input  logic                    main_busn,     // low while the 68000 owns the bus
    input  logic [16:1]             main_addr,
    input  logic                    main_ldswn,
    input  logic [7:0]              main_dout,
    input  logic [7:0]              rom_data,
    input  logic                    rom_ok,
    input  logic                    dsp_rdy_n,
    output z80_bus_pkg::sound_sel_t sel,
    output logic [2:0]              reg_num,
    output logic [7:0]              bus_din,
    output logic [18:0]             rom_addr,
    output logic [7:0]              cpu_din,
    output logic [7:0]              main_din,
    output logic                    main_busakn,
    output logic [3:0]              bank,
    output logic                    dsp_rst
);
    import z80_bus_pkg::*;

    z80_addr_u  bus_a;
    logic       bus_wrn;
    logic       bus_rdn;
    logic       bus_mreqn;
    logic       rom_area;
    logic       ram_area;
    logic       reg_page;
    logic       rom_ok2;
    logic       ram_we;
    logic [7:0] ram_dout;
    logic [7:0] ram [0:8191];   // 8 kB work RAM

    // the 68000 has no mreq, its accesses count as memory cycles
    assign bus_a     = main_busn ? cpu.addr : main_addr;
    assign bus_wrn   = main_busn ? cpu.wr_n : main_ldswn;
    assign bus_rdn   = main_busn ? cpu.rd_n : ~main_ldswn;
    assign bus_mreqn = main_busn & cpu.mreq_n;
    assign bus_din   = main_busn ? cpu.dout : main_dout;

    assign rom_area = bus_a.pg.page <= 4'hb;   // 0000-7fff fixed, 8000-bfff banked
    assign ram_area = bus_a.pg.page == 4'hc || bus_a.pg.page == 4'hf;
    assign reg_page = bus_a.pg.page == 4'hd;

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            sel     <= '0;
            rom_ok2 <= 1'b0;
        end else begin
            rom_ok2       <= rom_ok;
            sel.rom_sel   <= !bus_mreqn && rom_area;
            sel.ram_sel   <= !bus_mreqn && ram_area;
            sel.mbox_wr   <= !bus_mreqn && !bus_wrn && reg_page &&
                             bus_a.rg.reg_num <= `QSND_REG_ADDR;
            sel.bank_wr   <= !bus_mreqn && !bus_wrn && reg_page &&
                             bus_a.rg.reg_num == `QSND_REG_BANK;
            sel.status_rd <= !bus_mreqn && !bus_rdn && reg_page &&
                             bus_a.rg.reg_num == `QSND_REG_STATUS;
        end
    end

    always_ff @(posedge clk48) begin
        main_din <= cpu_din;   // 68000 read path, one cycle behind
        if (!bus_mreqn) begin
            reg_num  <= bus_a.rg.reg_num;
            rom_addr <= bus_a[15] ? {1'b0, bank, bus_a[13:0]} + `QSND_BANK_BASE
                                  : {4'd0, bus_a[14:0]};
        end
    end

    // bit 7 set releases the DSP from reset
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            bank    <= 4'd0;
            dsp_rst <= 1'b1;
        end else if (sel.bank_wr) begin
            bank    <= bus_din[3:0];
            dsp_rst <= ~bus_din[7];
        end
    end

    assign ram_we = sel.ram_sel && !bus_wrn;

    always_ff @(posedge clk48) begin
        if (ram_we)
            ram[bus_a[12:0]] <= bus_din;
        ram_dout <= ram[bus_a[12:0]];
    end

    always_comb begin
        if (sel.rom_sel)
            cpu_din = rom_data;
        else if (sel.ram_sel)
            cpu_din = ram_dout;
        else if (sel.status_rd)
            cpu_din = {dsp_rdy_n, 3'b111, bank};
        else
            cpu_din = 8'hff;   // open bus
    end

    // ack withheld while a ROM fetch is still waiting for the SDRAM
    assign main_busakn = main_busn | (sel.rom_sel & ~rom_ok2);

endmodule

// File: logic/dsp_link_pkg.sv
// DSP16 side types; serial audio is taken as parallel words, not shifted bits
package dsp_link_pkg;

    // outputs of the DSP16 core as seen by the glue
    typedef struct packed {
        logic        pids_n;    // parallel input strobe
        logic        pods_n;    // parallel output strobe
        logic        sadd;
        logic        psel;
        logic        ext_rq;
        logic        iack;
        logic [15:0] ab;
        logic [15:0] ser_out;
        logic [15:0] pbus_out;
    } dsp_port_t;

    // command built by the Z80 before it interrupts the DSP
    typedef struct packed {
        logic [7:0]  addr;
        logic [15:0] data;
    } qsnd_cmd_t;

    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } stereo_t;

endpackage

// File: logic/z80_bus_pkg.sv
// Z80 side types; addresses are 16 bits and data 8 bits, no refresh or halt modelled
package z80_bus_pkg;

    // what the Z80 core drives, strobes active low
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        mreq_n;
        logic        rd_n;
        logic        wr_n;
        logic        m1_n;
        logic        iorq_n;
    } z80_bus_t;

    // registered chip selects, one cycle behind the strobes
    typedef struct packed {
        logic rom_sel;
        logic ram_sel;
        logic mbox_wr;
        logic bank_wr;
        logic status_rd;
    } sound_sel_t;

    // memory decode view
    typedef struct packed {
        logic [3:0]  page;
        logic [11:0] offset;
    } page_view_t;

    // register decode view for the d000 page
    typedef struct packed {
        logic [12:0] upper;
        logic [2:0]  reg_num;
    } reg_view_t;

    typedef union packed {
        page_view_t pg;
        reg_view_t  rg;
    } z80_addr_u;

endpackage

// File: logic/qsnd_macros.svh
// constants assume the CPS-1.5 sound map and an 8 MHz Z80 clock enable
`ifndef QSND_MACROS_SVH
`define QSND_MACROS_SVH

// interrupt timer length in cen8 ticks, 250 Hz at 8 MHz
`define QSND_INT_PERIOD 32000

// added to every access in the 8000-bfff bank window
`define QSND_BANK_BASE 19'h08000

// register numbers inside the d000 page
`define QSND_REG_DATA_HI 3'd0
`define QSND_REG_DATA_LO 3'd1
`define QSND_REG_ADDR    3'd2   // writing it starts a DSP transfer
`define QSND_REG_BANK    3'd3
`define QSND_REG_STATUS  3'd7

`endif
